// ==== logic/buffer_cfg_pkg.sv ====
// buffer configuration
// sizes and plain vector types shared by the capture and readout domains
`default_nettype none

package buffer_cfg_pkg;

  // one input lane and one bank per channel
  localparam int CHANNELS = 4;
  localparam int BUFFER_DEPTH = 16;
  localparam int DATA_WIDTH = 16;
  // memory output register plus one pipeline stage
  localparam int READ_LATENCY = 2;

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int BANK_IDX_WIDTH = $clog2(CHANNELS);
  // highest banking mode gives one lane per bank
  localparam int MAX_BANKING_MODE = BANK_IDX_WIDTH;

  typedef logic [DATA_WIDTH-1:0] sample_t;
  typedef logic [ADDR_WIDTH-1:0] bank_addr_t;
  typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;
  // extra msb holds the full flag so a full bank reads as BUFFER_DEPTH
  typedef logic [ADDR_WIDTH:0] bank_depth_t;
  typedef logic [1:0] banking_mode_t;
  // 2^m active lanes, 1 to CHANNELS
  typedef logic [BANK_IDX_WIDTH:0] lane_count_t;
  typedef logic [CHANNELS-1:0] lane_mask_t;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ACTIVE,
    CAP_FULL
  } capture_state_t;

endpackage

`default_nettype wire

// ==== logic/stream_pkg.sv ====
// stream structs for the capture lanes, the bank write port and readout beats
`default_nettype none

package stream_pkg;

  // parallel converter lanes, each with its own valid
  typedef struct packed {
    buffer_cfg_pkg::sample_t [buffer_cfg_pkg::CHANNELS-1:0] data;
    buffer_cfg_pkg::lane_mask_t valid;
  } capture_lanes_t;

  // one write port per bank
  // router fills data and enable, tracker fills the address
  typedef struct packed {
    buffer_cfg_pkg::lane_mask_t enable;
    buffer_cfg_pkg::bank_addr_t [buffer_cfg_pkg::CHANNELS-1:0] addr;
    buffer_cfg_pkg::sample_t [buffer_cfg_pkg::CHANNELS-1:0] data;
  } bank_write_t;

  // readout stream payload, valid and ready travel beside it
  typedef struct packed {
    buffer_cfg_pkg::sample_t data;
    logic last;
  } readout_beat_t;

endpackage

`default_nettype wire

// ==== logic/capture_control.sv ====
// capture control FSM
// start/stop edge detect, banking latch and the bank chaining masks
`timescale 1ns/1ps
`default_nettype none

module capture_control (
  input wire logic capture_clk,
  input wire logic capture_reset,
  input wire buffer_cfg_pkg::banking_mode_t capture_banking_mode,
  input wire logic capture_start,
  input wire logic capture_stop,
  input wire logic capture_sw_reset,
  input wire buffer_cfg_pkg::lane_mask_t bank_full_now,
  input wire buffer_cfg_pkg::lane_mask_t bank_full_latch,
  output logic capture_active,
  output buffer_cfg_pkg::lane_mask_t lane_valid_mask,
  output buffer_cfg_pkg::lane_count_t active_lanes,
  output logic capture_full
);

  logic start_d;
  logic stop_d;
  logic start_edge;
  logic stop_edge;
  logic chain_end_full;
  buffer_cfg_pkg::banking_mode_t mode_sel;
  buffer_cfg_pkg::banking_mode_t mode_q;
  buffer_cfg_pkg::lane_count_t start_lanes;
  buffer_cfg_pkg::lane_mask_t full_mask;
  buffer_cfg_pkg::capture_state_t state;

  ////////////////////////////////////////
  // edge detect and banking latch
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      start_d <= 1'b0;
      stop_d <= 1'b0;
    end else begin
      start_d <= capture_start;
      stop_d <= capture_stop;
    end
  end

  assign start_edge = capture_start & ~start_d;
  assign stop_edge = capture_stop & ~stop_d;

  // out of range modes fall back to one lane per bank
  assign mode_sel = (capture_banking_mode > buffer_cfg_pkg::MAX_BANKING_MODE) ?
                    buffer_cfg_pkg::banking_mode_t'(buffer_cfg_pkg::MAX_BANKING_MODE) :
                    capture_banking_mode;
  assign start_lanes = buffer_cfg_pkg::lane_count_t'(1) << mode_sel;
  assign active_lanes = buffer_cfg_pkg::lane_count_t'(1) << mode_q;

  // full mask marks the top 2^m banks, the last bank of every chain
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      mode_q <= '0;
      full_mask <= '0;
    end else if (start_edge) begin
      mode_q <= mode_sel;
      for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
        full_mask[buffer_cfg_pkg::CHANNELS-1-b] <= (b < int'(start_lanes));
      end
    end
  end

  // lane mask starts on the low 2^m banks
  // a filled bank hands over to the bank 2^m further along its chain
  always_ff @(posedge capture_clk) begin
    if (capture_reset | capture_sw_reset) begin
      lane_valid_mask <= '0;
    end else if (start_edge) begin
      for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
        // banks still holding an unread capture stay closed
        lane_valid_mask[b] <= (b < int'(start_lanes)) & ~bank_full_latch[b];
      end
    end else begin
      for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
        if (bank_full_now[b]) begin
          lane_valid_mask[b] <= 1'b0;
          if (lane_valid_mask[b] && (b + int'(active_lanes) < buffer_cfg_pkg::CHANNELS)) begin
            lane_valid_mask[b + int'(active_lanes)] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // capture state
  ////////////////////////////////////////

  assign chain_end_full = |(bank_full_now & full_mask);

  always_ff @(posedge capture_clk) begin
    if (capture_reset | capture_sw_reset) begin
      state <= buffer_cfg_pkg::CAP_IDLE;
    end else begin
      case (state)
        buffer_cfg_pkg::CAP_IDLE: begin
          if (start_edge) state <= buffer_cfg_pkg::CAP_ACTIVE;
        end
        buffer_cfg_pkg::CAP_ACTIVE: begin
          if (chain_end_full) state <= buffer_cfg_pkg::CAP_FULL;
          else if (stop_edge) state <= buffer_cfg_pkg::CAP_IDLE;
        end
        buffer_cfg_pkg::CAP_FULL: begin
          // leaves once readout done or sw reset clears the full latches
          if (start_edge) state <= buffer_cfg_pkg::CAP_ACTIVE;
          else if (!capture_full) state <= buffer_cfg_pkg::CAP_IDLE;
        end
        default: state <= buffer_cfg_pkg::CAP_IDLE;
      endcase
    end
  end

  assign capture_active = (state == buffer_cfg_pkg::CAP_ACTIVE);
  assign capture_full = |(full_mask & bank_full_latch);

  // chaining moves an enable along a chain, it never opens an extra bank
  a_lane_mask_count: assert property (@(posedge capture_clk) disable iff (capture_reset)
    $countones(lane_valid_mask) <= int'(active_lanes));

endmodule

`default_nettype wire

// ==== logic/bank_router.sv ====
// bank router
// registers the input lanes and steers each lane to the banks of its chain
`timescale 1ns/1ps
`default_nettype none

module bank_router (
  input wire logic capture_clk,
  input wire stream_pkg::capture_lanes_t capture_in,
  input wire logic capture_active,
  input wire buffer_cfg_pkg::lane_mask_t lane_valid_mask,
  input wire buffer_cfg_pkg::lane_count_t active_lanes,
  output stream_pkg::bank_write_t bank_wr
);

  stream_pkg::capture_lanes_t lanes_q;
  buffer_cfg_pkg::bank_idx_t lane_wrap;
  buffer_cfg_pkg::bank_idx_t [buffer_cfg_pkg::CHANNELS-1:0] lane_sel;

  // input register stage
  always_ff @(posedge capture_clk) begin
    lanes_q <= capture_in;
  end

  // active_lanes is a power of two so b mod active_lanes is a mask
  assign lane_wrap = buffer_cfg_pkg::bank_idx_t'(active_lanes - 1'b1);

  always_comb begin
    // addresses come from the write tracker
    bank_wr.addr = '0;
    for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
      lane_sel[b] = buffer_cfg_pkg::bank_idx_t'(b) & lane_wrap;
      bank_wr.data[b] = lanes_q.data[lane_sel[b]];
      bank_wr.enable[b] = capture_active & lane_valid_mask[b] & lanes_q.valid[lane_sel[b]];
    end
  end

endmodule

`default_nettype wire

// ==== logic/bank_write_tracker.sv ====
// bank write tracker
// per-bank write address, full latch and reported depth
`timescale 1ns/1ps
`default_nettype none

module bank_write_tracker (
  input wire logic capture_clk,
  input wire logic capture_reset,
  input wire stream_pkg::bank_write_t bank_wr_in,
  input wire logic capture_sw_reset,
  input wire logic capture_done_clear,
  output stream_pkg::bank_write_t bank_wr_out,
  output buffer_cfg_pkg::lane_mask_t bank_full_now,
  output buffer_cfg_pkg::lane_mask_t bank_full_latch,
  output buffer_cfg_pkg::bank_depth_t [buffer_cfg_pkg::CHANNELS-1:0] capture_write_depth
);

  buffer_cfg_pkg::bank_addr_t [buffer_cfg_pkg::CHANNELS-1:0] write_addr;
  logic clear;

  // both a software reset and a finished readout reopen every bank
  assign clear = capture_sw_reset | capture_done_clear;

  // a bank fills on the write to its top address
  always_comb begin
    for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
      bank_full_now[b] = bank_wr_in.enable[b] &
        (write_addr[b] == buffer_cfg_pkg::bank_addr_t'(buffer_cfg_pkg::BUFFER_DEPTH - 1));
    end
  end

  always_ff @(posedge capture_clk) begin
    if (capture_reset | clear) begin
      write_addr <= '0;
      bank_full_latch <= '0;
    end else begin
      for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
        // the top address wraps to 0, the latch keeps the count at 16
        if (bank_wr_in.enable[b]) write_addr[b] <= write_addr[b] + 1'b1;
        if (bank_full_now[b]) bank_full_latch[b] <= 1'b1;
      end
    end
  end

  // write port stage, the address is taken before its increment
  always_ff @(posedge capture_clk) begin
    bank_wr_out.addr <= write_addr;
    bank_wr_out.data <= bank_wr_in.data;
    if (capture_reset) bank_wr_out.enable <= '0;
    else bank_wr_out.enable <= bank_wr_in.enable;
  end

  // depth trails the address by one cycle
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      capture_write_depth <= '0;
    end else begin
      for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
        capture_write_depth[b] <= {bank_full_latch[b], write_addr[b]};
      end
    end
  end

  // the control masks must have closed a bank before its latch is seen
  a_no_write_when_full: assert property (@(posedge capture_clk) disable iff (capture_reset)
    (bank_wr_in.enable & bank_full_latch) == '0);

endmodule

`default_nettype wire

// ==== logic/sample_bank_memory.sv ====
// sample bank storage
// one write port per bank on capture_clk, one shared read port on readout_clk
`timescale 1ns/1ps
`default_nettype none

module sample_bank_memory (
  input wire logic capture_clk,
  input wire stream_pkg::bank_write_t bank_wr,
  input wire logic readout_clk,
  input wire buffer_cfg_pkg::bank_idx_t rd_bank,
  input wire buffer_cfg_pkg::bank_addr_t rd_addr,
  input wire logic rd_enable,
  output buffer_cfg_pkg::sample_t rd_data
);

  buffer_cfg_pkg::sample_t storage [buffer_cfg_pkg::CHANNELS][buffer_cfg_pkg::BUFFER_DEPTH];

  always_ff @(posedge capture_clk) begin
    for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
      if (bank_wr.enable[b]) storage[b][bank_wr.addr[b]] <= bank_wr.data[b];
    end
  end

  // registered read, holds while the readout pipeline is frozen
  always_ff @(posedge readout_clk) begin
    if (rd_enable) rd_data <= storage[rd_bank][rd_addr];
  end

endmodule

`default_nettype wire

// ==== logic/readout_sequencer.sv ====
// readout sequencer
// walks every bank and address and streams the samples out under back-pressure
`timescale 1ns/1ps
`default_nettype none

module readout_sequencer (
  input wire logic readout_clk,
  input wire logic readout_reset,
  input wire logic readout_start,
  input wire logic readout_sw_reset,
  output buffer_cfg_pkg::bank_idx_t rd_bank,
  output buffer_cfg_pkg::bank_addr_t rd_addr,
  output logic rd_enable,
  input wire buffer_cfg_pkg::sample_t rd_data,
  output stream_pkg::readout_beat_t readout_beat,
  output logic readout_valid,
  input wire logic readout_ready,
  output logic readout_done_pulse
);

  logic start_d;
  logic start_edge;
  logic active;
  logic advance;
  logic issue_last;
  // stage 0 lines up with the memory output register
  logic [buffer_cfg_pkg::READ_LATENCY-1:0] valid_pipe;
  logic [buffer_cfg_pkg::READ_LATENCY-1:0] last_pipe;
  buffer_cfg_pkg::sample_t [buffer_cfg_pkg::READ_LATENCY-1:1] data_pipe;
  buffer_cfg_pkg::sample_t [buffer_cfg_pkg::READ_LATENCY-1:0] data_shift;
  buffer_cfg_pkg::sample_t beat_data;
  logic beat_last;

  always_ff @(posedge readout_clk) begin
    if (readout_reset) start_d <= 1'b0;
    else start_d <= readout_start;
  end

  assign start_edge = readout_start & ~start_d;

  // whole pipeline moves only when the output slot is free or taken
  assign advance = readout_ready | ~readout_valid;
  assign rd_enable = advance & active;
  assign issue_last = active &
    (rd_addr == buffer_cfg_pkg::bank_addr_t'(buffer_cfg_pkg::BUFFER_DEPTH - 1)) &
    (rd_bank == buffer_cfg_pkg::bank_idx_t'(buffer_cfg_pkg::CHANNELS - 1));

  ////////////////////////////////////////
  // address walk
  ////////////////////////////////////////

  // sizes are powers of two so both counters wrap on their own
  always_ff @(posedge readout_clk) begin
    if (readout_reset | readout_sw_reset) begin
      active <= 1'b0;
      rd_addr <= '0;
      rd_bank <= '0;
    end else if (start_edge) begin
      active <= 1'b1;
      rd_addr <= '0;
      rd_bank <= '0;
    end else if (active & advance) begin
      if (issue_last) active <= 1'b0;
      rd_addr <= rd_addr + 1'b1;
      if (rd_addr == buffer_cfg_pkg::bank_addr_t'(buffer_cfg_pkg::BUFFER_DEPTH - 1)) begin
        rd_bank <= rd_bank + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // read latency pipeline
  ////////////////////////////////////////

  assign data_shift = {data_pipe, rd_data};

  always_ff @(posedge readout_clk) begin
    if (advance) begin
      data_pipe <= data_shift[buffer_cfg_pkg::READ_LATENCY-2:0];
      beat_data <= data_shift[buffer_cfg_pkg::READ_LATENCY-1];
    end
  end

  always_ff @(posedge readout_clk) begin
    if (readout_reset | readout_sw_reset) begin
      valid_pipe <= '0;
      last_pipe <= '0;
      readout_valid <= 1'b0;
      beat_last <= 1'b0;
    end else if (advance) begin
      valid_pipe <= {valid_pipe[buffer_cfg_pkg::READ_LATENCY-2:0], active};
      last_pipe <= {last_pipe[buffer_cfg_pkg::READ_LATENCY-2:0], issue_last};
      readout_valid <= valid_pipe[buffer_cfg_pkg::READ_LATENCY-1];
      beat_last <= last_pipe[buffer_cfg_pkg::READ_LATENCY-1];
    end
  end

  assign readout_beat = '{data: beat_data, last: beat_last};
  // one cycle, on the accepted last beat
  assign readout_done_pulse = readout_valid & readout_ready & beat_last;

  // a stalled beat survives the frozen memory and pipeline stages
  a_beat_hold: assert property (@(posedge readout_clk) disable iff (readout_reset)
    readout_valid && !readout_ready && !readout_sw_reset
    |=> readout_valid && $stable(readout_beat));

endmodule

`default_nettype wire

// ==== logic/done_handshake_sync.sv ====
// readout done crossing
// four-phase req/ack handshake from readout_clk to capture_clk, one event held
`timescale 1ns/1ps
`default_nettype none

module done_handshake_sync (
  input wire logic readout_clk,
  input wire logic readout_reset,
  input wire logic readout_done_pulse,
  input wire logic capture_clk,
  input wire logic capture_reset,
  output logic capture_done_clear
);

  logic req;
  logic pending;
  logic [1:0] ack_sync;
  logic ack;
  logic [1:0] req_sync;
  logic src_idle;

  ////////////////////////////////////////
  // readout side
  ////////////////////////////////////////

  // idle once req is low and the synced ack has dropped
  assign src_idle = ~req & ~ack_sync[1];

  always_ff @(posedge readout_clk) begin
    if (readout_reset) begin
      ack_sync <= '0;
      req <= 1'b0;
      pending <= 1'b0;
    end else begin
      ack_sync <= {ack_sync[0], ack};
      if (src_idle) begin
        if (readout_done_pulse | pending) req <= 1'b1;
        // a new pulse alongside a held one stays held
        pending <= readout_done_pulse & pending;
      end else begin
        if (req & ack_sync[1]) req <= 1'b0;
        if (readout_done_pulse) pending <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // capture side
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      req_sync <= '0;
      ack <= 1'b0;
    end else begin
      req_sync <= {req_sync[0], req};
      // ack follows the synced req one cycle later
      ack <= req_sync[1];
    end
  end

  // high for the single cycle between req arriving and ack rising
  assign capture_done_clear = req_sync[1] & ~ack;

endmodule

`default_nettype wire

// ==== logic/capture_buffer_top.sv ====
// dual clock capture buffer top
// capture control and datapath on capture_clk, readout stream on readout_clk
`timescale 1ns/1ps
`default_nettype none

module capture_buffer_top (
  // capture domain
  input wire logic capture_clk,
  input wire logic capture_reset,
  input wire stream_pkg::capture_lanes_t capture_in,
  input wire buffer_cfg_pkg::banking_mode_t capture_banking_mode,
  input wire logic capture_start,
  input wire logic capture_stop,
  input wire logic capture_sw_reset,
  output logic capture_full,
  output buffer_cfg_pkg::bank_depth_t [buffer_cfg_pkg::CHANNELS-1:0] capture_write_depth,
  // readout domain
  input wire logic readout_clk,
  input wire logic readout_reset,
  input wire logic readout_start,
  input wire logic readout_sw_reset,
  output stream_pkg::readout_beat_t readout_beat,
  output logic readout_valid,
  input wire logic readout_ready
);

  logic capture_active;
  buffer_cfg_pkg::lane_mask_t lane_valid_mask;
  buffer_cfg_pkg::lane_count_t active_lanes;
  buffer_cfg_pkg::lane_mask_t bank_full_now;
  buffer_cfg_pkg::lane_mask_t bank_full_latch;
  logic capture_done_clear;
  stream_pkg::bank_write_t routed_wr;
  stream_pkg::bank_write_t bank_wr;
  buffer_cfg_pkg::bank_idx_t rd_bank;
  buffer_cfg_pkg::bank_addr_t rd_addr;
  logic rd_enable;
  buffer_cfg_pkg::sample_t rd_data;
  logic readout_done_pulse;

  capture_control control_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .capture_banking_mode(capture_banking_mode),
    .capture_start(capture_start),
    .capture_stop(capture_stop),
    .capture_sw_reset(capture_sw_reset),
    .bank_full_now(bank_full_now),
    .bank_full_latch(bank_full_latch),
    .capture_active(capture_active),
    .lane_valid_mask(lane_valid_mask),
    .active_lanes(active_lanes),
    .capture_full(capture_full)
  );

  bank_router router_i (
    .capture_clk(capture_clk),
    .capture_in(capture_in),
    .capture_active(capture_active),
    .lane_valid_mask(lane_valid_mask),
    .active_lanes(active_lanes),
    .bank_wr(routed_wr)
  );

  bank_write_tracker tracker_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .bank_wr_in(routed_wr),
    .capture_sw_reset(capture_sw_reset),
    .capture_done_clear(capture_done_clear),
    .bank_wr_out(bank_wr),
    .bank_full_now(bank_full_now),
    .bank_full_latch(bank_full_latch),
    .capture_write_depth(capture_write_depth)
  );

  sample_bank_memory memory_i (
    .capture_clk(capture_clk),
    .bank_wr(bank_wr),
    .readout_clk(readout_clk),
    .rd_bank(rd_bank),
    .rd_addr(rd_addr),
    .rd_enable(rd_enable),
    .rd_data(rd_data)
  );

  readout_sequencer sequencer_i (
    .readout_clk(readout_clk),
    .readout_reset(readout_reset),
    .readout_start(readout_start),
    .readout_sw_reset(readout_sw_reset),
    .rd_bank(rd_bank),
    .rd_addr(rd_addr),
    .rd_enable(rd_enable),
    .rd_data(rd_data),
    .readout_beat(readout_beat),
    .readout_valid(readout_valid),
    .readout_ready(readout_ready),
    .readout_done_pulse(readout_done_pulse)
  );

  // done crossing back to capture_clk clears addresses and full latches
  done_handshake_sync done_sync_i (
    .readout_clk(readout_clk),
    .readout_reset(readout_reset),
    .readout_done_pulse(readout_done_pulse),
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .capture_done_clear(capture_done_clear)
  );

endmodule

`default_nettype wire

// ==== verification/capture_buffer_tb.sv ====
// capture buffer testbench
// lane stimulus, a bank model and assertion checks on depths, full flag and readout beats
`timescale 1ns/1ps
`default_nettype none

module capture_buffer_tb;

  localparam int CAPTURE_PERIOD = 8;
  localparam int READOUT_PERIOD = 20;
  localparam int TOTAL_BEATS = buffer_cfg_pkg::CHANNELS * buffer_cfg_pkg::BUFFER_DEPTH;
  // limit in capture cycles for a done crossing of about 8 readout cycles
  localparam int CLEAR_LIMIT = 40;
  localparam int READOUT_LIMIT = 4 * TOTAL_BEATS;
  // five capture phases and two readouts of about two cycles per beat plus margin
  localparam int WATCHDOG_NS = 600 * CAPTURE_PERIOD +
                               2 * (2 * TOTAL_BEATS + 10) * READOUT_PERIOD + 2000;

  // DUT inputs
  logic capture_clk = 1'b0;
  logic capture_reset = 1'b1;
  stream_pkg::capture_lanes_t capture_in = '0;
  buffer_cfg_pkg::banking_mode_t capture_banking_mode = '0;
  logic capture_start = 1'b0;
  logic capture_stop = 1'b0;
  logic capture_sw_reset = 1'b0;
  logic readout_clk = 1'b0;
  logic readout_reset = 1'b1;
  logic readout_start = 1'b0;
  logic readout_sw_reset = 1'b0;
  logic readout_ready = 1'b0;

  // DUT outputs
  logic capture_full;
  buffer_cfg_pkg::bank_depth_t [buffer_cfg_pkg::CHANNELS-1:0] capture_write_depth;
  stream_pkg::readout_beat_t readout_beat;
  logic readout_valid;

  // bank model indexed by {bank, address} in readout order
  buffer_cfg_pkg::sample_t model_mem [TOTAL_BEATS];
  logic model_written [TOTAL_BEATS] = '{default: 1'b0};
  int bank_count [buffer_cfg_pkg::CHANNELS];
  int lane_written [buffer_cfg_pkg::CHANNELS];
  int lane_seq [buffer_cfg_pkg::CHANNELS];
  int model_mode = 0;
  logic model_active = 1'b0;

  // check enables and expected values
  logic depth_check = 1'b0;
  logic full_check = 1'b0;
  logic expect_full = 1'b0;
  buffer_cfg_pkg::bank_depth_t [buffer_cfg_pkg::CHANNELS-1:0] expect_depth = '0;
  logic [6:0] beat_idx = '0;
  logic readout_running = 1'b0;
  buffer_cfg_pkg::sample_t expect_data;
  logic expect_written;
  int seed = 32'hff3c_05b7;

  capture_buffer_top UUT (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .capture_in(capture_in),
    .capture_banking_mode(capture_banking_mode),
    .capture_start(capture_start),
    .capture_stop(capture_stop),
    .capture_sw_reset(capture_sw_reset),
    .capture_full(capture_full),
    .capture_write_depth(capture_write_depth),
    .readout_clk(readout_clk),
    .readout_reset(readout_reset),
    .readout_start(readout_start),
    .readout_sw_reset(readout_sw_reset),
    .readout_beat(readout_beat),
    .readout_valid(readout_valid),
    .readout_ready(readout_ready)
  );

  always #(CAPTURE_PERIOD / 2) capture_clk = ~capture_clk;
  always #(READOUT_PERIOD / 2) readout_clk = ~readout_clk;

  initial begin
    repeat (3) @(posedge readout_clk);
    readout_reset <= 1'b0;
  end

  // roughly three of four readout cycles ready
  always @(posedge readout_clk) begin
    readout_ready <= ($random(seed) & 3) != 0;
  end

  // beat index of the running readout cleared by the start command
  always @(posedge readout_clk) begin
    if (readout_reset) begin
      beat_idx <= '0;
      readout_running <= 1'b0;
    end else if (readout_start) begin
      beat_idx <= '0;
      readout_running <= 1'b1;
    end else if (readout_valid && readout_ready) begin
      beat_idx <= beat_idx + 1'b1;
      if (readout_beat.last) readout_running <= 1'b0;
    end
  end

  assign expect_data = model_mem[beat_idx[5:0]];
  assign expect_written = model_written[beat_idx[5:0]];

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // assertion checks
  ////////////////////////////////////////

  a_depth: assert property (@(posedge capture_clk) disable iff (capture_reset)
    depth_check |-> capture_write_depth == expect_depth)
    else fail_stop($sformatf("ERROR %0t capture_write_depth got %h expected %h", $time,
                             $sampled(capture_write_depth), $sampled(expect_depth)));

  a_full: assert property (@(posedge capture_clk) disable iff (capture_reset)
    full_check |-> capture_full == expect_full)
    else fail_stop($sformatf("ERROR %0t capture_full got %b expected %b", $time,
                             $sampled(capture_full), $sampled(expect_full)));

  // no beat outside a readout and none after reset
  a_idle_valid: assert property (@(posedge readout_clk) disable iff (readout_reset)
    !readout_running |-> !readout_valid)
    else fail_stop($sformatf("ERROR %0t readout_valid got %b expected 0", $time,
                             $sampled(readout_valid)));

  // only slots written by the model carry a known sample
  a_beat_data: assert property (@(posedge readout_clk) disable iff (readout_reset)
    readout_valid && readout_ready && expect_written |-> readout_beat.data == expect_data)
    else fail_stop($sformatf("ERROR %0t readout_beat.data got %h expected %h", $time,
                             $sampled(readout_beat.data), $sampled(expect_data)));

  a_beat_last: assert property (@(posedge readout_clk) disable iff (readout_reset)
    readout_valid && readout_ready |-> readout_beat.last == (int'(beat_idx) == TOTAL_BEATS - 1))
    else fail_stop($sformatf("ERROR %0t readout_beat.last got %b expected %b", $time,
                             $sampled(readout_beat.last),
                             $sampled(int'(beat_idx) == TOTAL_BEATS - 1)));

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // sample j of lane c goes to bank c + (j div 16) * 2^m at address j mod 16
  function automatic void record_sample(input int c, input buffer_cfg_pkg::sample_t word);
    int j;
    int bank;
    logic [5:0] slot;
    j = lane_written[c];
    bank = c + (j / buffer_cfg_pkg::BUFFER_DEPTH) * (1 << model_mode);
    if (bank < buffer_cfg_pkg::CHANNELS) begin
      slot = {buffer_cfg_pkg::bank_idx_t'(bank),
              buffer_cfg_pkg::bank_addr_t'(j % buffer_cfg_pkg::BUFFER_DEPTH)};
      model_mem[slot] = word;
      model_written[slot] = 1'b1;
      bank_count[bank]++;
      lane_written[c]++;
    end
  endfunction

  // the top 2^m banks end the chains
  function automatic logic chain_end_filled();
    logic hit;
    hit = 1'b0;
    for (int b = buffer_cfg_pkg::CHANNELS - (1 << model_mode); b < buffer_cfg_pkg::CHANNELS;
         b++) begin
      if (bank_count[b] == buffer_cfg_pkg::BUFFER_DEPTH) hit = 1'b1;
    end
    return hit;
  endfunction

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic checks_off();
    @(posedge capture_clk);
    depth_check <= 1'b0;
    full_check <= 1'b0;
  endtask

  task automatic begin_capture(input int mode);
    checks_off();
    model_mode = mode;
    model_active = 1'b1;
    for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
      bank_count[b] = 0;
      lane_written[b] = 0;
      lane_seq[b] = 0;
    end
    for (int i = 0; i < TOTAL_BEATS; i++) begin
      model_written[i] = 1'b0;
    end
    @(posedge capture_clk);
    capture_banking_mode <= buffer_cfg_pkg::banking_mode_t'(mode);
    capture_start <= 1'b1;
    @(posedge capture_clk);
    capture_start <= 1'b0;
    @(posedge capture_clk);
  endtask

  // every lane valid on every cycle with the sample word {lane, sequence number}
  task automatic drive_lanes(input int cycles);
    stream_pkg::capture_lanes_t lanes;
    for (int n = 0; n < cycles; n++) begin
      for (int c = 0; c < buffer_cfg_pkg::CHANNELS; c++) begin
        lanes.data[c] = {4'(c), 12'(lane_seq[c])};
        lanes.valid[c] = 1'b1;
        lane_seq[c]++;
        if (model_active && c < (1 << model_mode)) record_sample(c, lanes.data[c]);
      end
      if (chain_end_filled()) model_active = 1'b0;
      @(posedge capture_clk);
      capture_in <= lanes;
    end
  endtask

  task automatic stop_capture();
    @(posedge capture_clk);
    capture_in.valid <= '0;
    capture_stop <= 1'b1;
    model_active = 1'b0;
    @(posedge capture_clk);
    capture_stop <= 1'b0;
  endtask

  task automatic settle_and_check();
    @(posedge capture_clk);
    capture_in.valid <= '0;
    // a sample lands two cycles after its edge and the depth one cycle later
    repeat (5) @(posedge capture_clk);
    for (int b = 0; b < buffer_cfg_pkg::CHANNELS; b++) begin
      expect_depth[b] <= buffer_cfg_pkg::bank_depth_t'(bank_count[b]);
    end
    expect_full <= chain_end_filled();
    depth_check <= 1'b1;
    full_check <= 1'b1;
    repeat (4) @(posedge capture_clk);
  endtask

  // depths and full flag must return to zero and stay there
  task automatic wait_capture_clear(input string cause);
    int n;
    n = 0;
    @(negedge capture_clk);
    while ((capture_full || capture_write_depth != '0) && n < CLEAR_LIMIT) begin
      @(negedge capture_clk);
      n++;
    end
    if (capture_full || capture_write_depth != '0) begin
      fail_stop($sformatf("%s did not clear the depths and the full flag", cause));
    end
    @(posedge capture_clk);
    expect_depth <= '0;
    expect_full <= 1'b0;
    depth_check <= 1'b1;
    full_check <= 1'b1;
    repeat (4) @(posedge capture_clk);
  endtask

  task automatic run_readout();
    int n;
    checks_off();
    @(posedge readout_clk);
    readout_start <= 1'b1;
    @(posedge readout_clk);
    readout_start <= 1'b0;
    n = 0;
    @(negedge readout_clk);
    while (readout_running && n < READOUT_LIMIT) begin
      @(negedge readout_clk);
      n++;
    end
    if (readout_running) fail_stop("readout did not deliver its last beat in time");
  endtask

  task automatic pulse_sw_reset();
    checks_off();
    @(posedge capture_clk);
    capture_sw_reset <= 1'b1;
    @(posedge capture_clk);
    capture_sw_reset <= 1'b0;
    wait_capture_clear("capture_sw_reset");
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    fail_stop("watchdog expired before the tests finished");
  end

  initial begin
    repeat (3) @(posedge capture_clk);
    capture_reset <= 1'b0;
    // idle right after reset with nothing written yet
    depth_check <= 1'b1;
    full_check <= 1'b1;
    repeat (4) @(posedge capture_clk);
    // mode 0 with lane 0 running through banks 0 to 3
    begin_capture(0);
    drive_lanes(TOTAL_BEATS + 4);
    settle_and_check();
    run_readout();
    wait_capture_clear("readout done");
    // mode 2 with one lane per bank
    begin_capture(2);
    drive_lanes(buffer_cfg_pkg::BUFFER_DEPTH + 4);
    settle_and_check();
    run_readout();
    wait_capture_clear("readout done");
    // mode 1 stopped early so later samples are ignored
    begin_capture(1);
    drive_lanes(10);
    stop_capture();
    settle_and_check();
    drive_lanes(8);
    settle_and_check();
    pulse_sw_reset();
    // full capture dropped by software reset
    begin_capture(2);
    drive_lanes(buffer_cfg_pkg::BUFFER_DEPTH + 2);
    settle_and_check();
    pulse_sw_reset();
    repeat (4) @(posedge capture_clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/buffer_cfg_pkg.sv
logic/stream_pkg.sv
logic/capture_control.sv
logic/bank_router.sv
logic/bank_write_tracker.sv
logic/sample_bank_memory.sv
logic/readout_sequencer.sv
logic/done_handshake_sync.sv
logic/capture_buffer_top.sv
verification/capture_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the capture buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module capture_buffer_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcapture_buffer_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^All checks passed$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
